/* verilog/vend_pkg.sv */
package vend_pkg;

    //////////////////////////////
    // value types
    //////////////////////////////

    // money in units of 100 won
    typedef logic [7:0] money_t;
    // stock count of one product
    typedef logic [3:0] count_t;
    // 0 means no product, 1 to 3 are the products
    typedef logic [1:0] prod_id_t;
    // piezo playback phase, 0 when silent
    typedef logic [2:0] phase_t;

    localparam int NUM_PRODUCTS = 3;

    // price per product id
    localparam money_t PRICE [1:NUM_PRODUCTS] = '{8'd10, 8'd12, 8'd15};

    // stock after reset and the restock ceiling
    localparam count_t STOCK_INIT [1:NUM_PRODUCTS] = '{4'd5, 4'd1, 4'd0};
    localparam count_t STOCK_LIMIT = 4'd9;

    // value of each one-hot coin key bit
    localparam money_t COIN_VALUE [0:2] = '{8'd1, 8'd5, 8'd10};

    typedef enum logic [2:0] {
        NOTE_NONE  = 3'd0,
        NOTE_100W  = 3'd1,
        NOTE_500W  = 3'd2,
        NOTE_1000W = 3'd3,
        NOTE_PROD1 = 3'd4,
        NOTE_PROD2 = 3'd5,
        NOTE_PROD3 = 3'd6
    } note_t;

endpackage

/* verilog/bus_pkg.sv */
package bus_pkg;

    //////////////////////////////
    // wishbone classic
    //////////////////////////////

    // master to slave
    typedef struct packed {
        logic               cyc;
        logic               stb;
        logic               we;
        vend_pkg::prod_id_t adr;
        vend_pkg::count_t   dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic             ack;
        vend_pkg::count_t dat;
    } wb_rsp_t;

    // one-cycle key pulses, at most one active per cycle
    typedef struct packed {
        logic       up;
        logic       down;
        logic       sel;
        logic       buy;
        logic       ret;
        logic       add;
        logic [2:0] coin;
    } keys_t;

endpackage

/* verilog/stock_ram.sv */
`timescale 1ns/100ps

module stock_ram (
    input  logic               clk,
    input  logic               rst,
    input  bus_pkg::wb_req_t   wb_req,
    output bus_pkg::wb_rsp_t   wb_rsp,
    input  vend_pkg::prod_id_t disp_adr,
    output vend_pkg::count_t   disp_count
);
    import vend_pkg::*;

    count_t stock [1:NUM_PRODUCTS];
    count_t rd_dat;
    logic   ack_q;
    logic   access;

    // new request that has not been acknowledged yet
    assign access = wb_req.cyc && wb_req.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            stock <= STOCK_INIT;
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
            if (access && wb_req.we) begin
                stock[wb_req.adr] <= wb_req.dat;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rd_dat <= stock[wb_req.adr];
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_dat;

    // display port, cursor is never 0
    assign disp_count = (disp_adr != '0) ? stock[disp_adr] : '0;

    a_write_limit: assert property (@(posedge clk) disable iff (!rst)
        access && wb_req.we |-> wb_req.dat <= STOCK_LIMIT);

endmodule

/* verilog/stock_arbiter.sv */
`timescale 1ns/100ps

module stock_arbiter (
    input  logic             clk,
    input  logic             rst,
    input  bus_pkg::wb_req_t m0_req,
    output bus_pkg::wb_rsp_t m0_rsp,
    input  bus_pkg::wb_req_t m1_req,
    output bus_pkg::wb_rsp_t m1_rsp,
    output bus_pkg::wb_req_t s_req,
    input  bus_pkg::wb_rsp_t s_rsp
);
    // 0 grants the sale side, 1 the restock side
    logic gnt;
    logic owner_cyc;

    assign owner_cyc = gnt ? m1_req.cyc : m0_req.cyc;

    always_ff @(posedge clk) begin
        if (!rst) begin
            gnt <= 1'b0;
        end else if (!owner_cyc) begin
            // rearbitrate only while the owner is idle, sale first
            if (m0_req.cyc) begin
                gnt <= 1'b0;
            end else if (m1_req.cyc) begin
                gnt <= 1'b1;
            end
        end
    end

    assign s_req = gnt ? m1_req : m0_req;

    // read data is shared, ack goes to the owner only
    assign m0_rsp.ack = s_rsp.ack & ~gnt;
    assign m0_rsp.dat = s_rsp.dat;
    assign m1_rsp.ack = s_rsp.ack & gnt;
    assign m1_rsp.dat = s_rsp.dat;

    //////////////////////////////
    // checks
    //////////////////////////////

    // an ack only lands inside the granted master's open cycle
    a_ack_owner: assert property (@(posedge clk) disable iff (!rst)
        s_rsp.ack |-> owner_cyc);

endmodule

/* verilog/sale_controller.sv */
`timescale 1ns/100ps

module sale_controller (
    input  logic               clk,
    input  logic               rst,
    input  bus_pkg::keys_t     keys,
    input  vend_pkg::money_t   credit,
    output vend_pkg::prod_id_t cursor,
    output vend_pkg::prod_id_t selected,
    output logic               vend,
    output vend_pkg::prod_id_t vend_item,
    output logic               charge,
    output vend_pkg::money_t   charge_amount,
    output logic               tone_start,
    output vend_pkg::note_t    tone_note,
    output bus_pkg::wb_req_t   wb_req,
    input  bus_pkg::wb_rsp_t   wb_rsp
);
    import vend_pkg::*;

    typedef enum logic [1:0] {IDLE, SEL_READ, BUY_READ, BUY_WRITE} state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state         <= IDLE;
            cursor        <= 2'd1;
            selected      <= '0;
            vend          <= 1'b0;
            vend_item     <= '0;
            charge        <= 1'b0;
            charge_amount <= '0;
            tone_start    <= 1'b0;
            tone_note     <= NOTE_NONE;
            wb_req        <= '0;
        end else begin
            // single-cycle pulses
            vend       <= 1'b0;
            charge     <= 1'b0;
            tone_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (keys.up && cursor > 2'd1) begin
                        cursor <= cursor - 2'd1;
                    end else if (keys.down && cursor < prod_id_t'(NUM_PRODUCTS)) begin
                        cursor <= cursor + 2'd1;
                    end else if (keys.sel) begin
                        // same item again means deselect
                        if (selected == cursor) begin
                            selected <= '0;
                        end else begin
                            wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: cursor, dat: '0};
                            state  <= SEL_READ;
                        end
                    end else if (keys.buy && selected != '0) begin
                        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: selected, dat: '0};
                        state  <= BUY_READ;
                    end
                end
                SEL_READ: begin
                    if (wb_rsp.ack) begin
                        wb_req.cyc <= 1'b0;
                        wb_req.stb <= 1'b0;
                        state      <= IDLE;
                        // out of stock items are refused
                        if (wb_rsp.dat != '0) begin
                            selected   <= wb_req.adr;
                            tone_start <= 1'b1;
                            case (wb_req.adr)
                                2'd1:    tone_note <= NOTE_PROD1;
                                2'd2:    tone_note <= NOTE_PROD2;
                                default: tone_note <= NOTE_PROD3;
                            endcase
                        end
                    end
                end
                BUY_READ: begin
                    if (wb_rsp.ack) begin
                        if (wb_rsp.dat != '0 && credit >= PRICE[wb_req.adr]) begin
                            // cyc stays up so the arbiter keeps the grant
                            wb_req.we  <= 1'b1;
                            wb_req.dat <= wb_rsp.dat - 4'd1;
                            state      <= BUY_WRITE;
                        end else begin
                            wb_req.cyc <= 1'b0;
                            wb_req.stb <= 1'b0;
                            state      <= IDLE;
                        end
                    end
                end
                BUY_WRITE: begin
                    if (wb_rsp.ack) begin
                        wb_req.cyc    <= 1'b0;
                        wb_req.stb    <= 1'b0;
                        wb_req.we     <= 1'b0;
                        vend          <= 1'b1;
                        vend_item     <= wb_req.adr;
                        charge        <= 1'b1;
                        charge_amount <= PRICE[wb_req.adr];
                        selected      <= '0;
                        state         <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // credit still covers the price when the item drops
    a_vend_covered: assert property (@(posedge clk) disable iff (!rst)
        vend |-> charge_amount <= credit);

endmodule

/* verilog/restock_controller.sv */
`timescale 1ns/100ps

module restock_controller (
    input  logic               clk,
    input  logic               rst,
    input  logic               add,
    input  logic               admin_mode,
    input  vend_pkg::prod_id_t cursor,
    output bus_pkg::wb_req_t   wb_req,
    input  bus_pkg::wb_rsp_t   wb_rsp
);
    import vend_pkg::*;

    typedef enum logic [1:0] {IDLE, READ, WRITE} state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state  <= IDLE;
            wb_req <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // admin only
                    if (add && admin_mode) begin
                        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: cursor, dat: '0};
                        state  <= READ;
                    end
                end
                READ: begin
                    if (wb_rsp.ack) begin
                        if (wb_rsp.dat < STOCK_LIMIT) begin
                            wb_req.we  <= 1'b1;
                            wb_req.dat <= wb_rsp.dat + 4'd1;
                            state      <= WRITE;
                        end else begin
                            // already full, close the cycle
                            wb_req.cyc <= 1'b0;
                            wb_req.stb <= 1'b0;
                            state      <= IDLE;
                        end
                    end
                end
                WRITE: begin
                    if (wb_rsp.ack) begin
                        wb_req.cyc <= 1'b0;
                        wb_req.stb <= 1'b0;
                        wb_req.we  <= 1'b0;
                        state      <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* verilog/coin_bank.sv */
`timescale 1ns/100ps

module coin_bank #(
    parameter int RETURN_TICKS
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [2:0]       coin,
    input  logic             ret,
    input  logic             charge,
    input  vend_pkg::money_t charge_amount,
    output vend_pkg::money_t credit,
    output logic             returning,
    output logic             tone_start,
    output vend_pkg::note_t  tone_note
);
    import vend_pkg::*;

    localparam int TW = $clog2(RETURN_TICKS + 1);

    logic [TW-1:0] tick_cnt;
    money_t        coin_add;
    money_t        charge_sub;

    // one-hot coin key to value
    always_comb begin
        coin_add = '0;
        for (int i = 0; i < 3; i++) begin
            if (coin[i]) begin
                coin_add = COIN_VALUE[i];
            end
        end
    end

    assign charge_sub = charge ? charge_amount : '0;

    always_ff @(posedge clk) begin
        if (!rst) begin
            credit     <= '0;
            returning  <= 1'b0;
            tick_cnt   <= '0;
            tone_start <= 1'b0;
            tone_note  <= NOTE_NONE;
        end else begin
            tone_start <= 1'b0;
            if (returning) begin
                // pay out one unit per tick
                if (tick_cnt == TW'(RETURN_TICKS - 1)) begin
                    tick_cnt <= '0;
                    if (credit != '0) begin
                        credit <= credit - 8'd1;
                    end else begin
                        returning <= 1'b0;
                    end
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end else if (ret) begin
                returning <= 1'b1;
                tick_cnt  <= '0;
            end else begin
                credit <= credit + coin_add - charge_sub;
                if (|coin) begin
                    tone_start <= 1'b1;
                    tone_note  <= coin[2] ? NOTE_1000W : (coin[1] ? NOTE_500W : NOTE_100W);
                end
            end
        end
    end

    // the sale side checked credit before it charged
    a_charge_covered: assert property (@(posedge clk) disable iff (!rst)
        charge && !returning |-> charge_amount <= credit);

endmodule

/* verilog/tone_sequencer.sv */
`timescale 1ns/100ps

module tone_sequencer #(
    parameter int PHASE_TICKS
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  vend_pkg::note_t  note,
    output vend_pkg::note_t  note_state,
    output vend_pkg::phase_t note_played
);
    import vend_pkg::*;

    localparam int TW = $clog2(PHASE_TICKS + 1);

    logic [TW-1:0] tick_cnt;

    always_ff @(posedge clk) begin
        if (!rst) begin
            note_state  <= NOTE_NONE;
            note_played <= '0;
            tick_cnt    <= '0;
        end else if (start) begin
            // a new tone restarts from phase 1
            note_state  <= note;
            note_played <= 3'd1;
            tick_cnt    <= '0;
        end else if (note_played != '0) begin
            if (tick_cnt == TW'(PHASE_TICKS - 1)) begin
                tick_cnt <= '0;
                if (note_played == 3'd4) begin
                    note_played <= '0;
                    note_state  <= NOTE_NONE;
                end else begin
                    note_played <= note_played + 3'd1;
                end
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

endmodule

/* verilog/vending_machine.sv */
`timescale 1ns/100ps

module vending_machine #(
    parameter int RETURN_TICKS = 1_000_000,
    parameter int PHASE_TICKS  = 100_000
) (
    input  logic               clk,
    input  logic               rst,
    input  bus_pkg::keys_t     keys,
    input  logic               admin_mode,
    output vend_pkg::money_t   credit,
    output vend_pkg::count_t   shown_count,
    output vend_pkg::prod_id_t cursor,
    output vend_pkg::prod_id_t selected,
    output logic               vend,
    output vend_pkg::prod_id_t vend_item,
    output logic               returning,
    output vend_pkg::note_t    note_state,
    output vend_pkg::phase_t   note_played
);
    import vend_pkg::*;
    import bus_pkg::*;

    // stock bus, sale side is master 0
    wb_req_t sale_req;
    wb_rsp_t sale_rsp;
    wb_req_t rest_req;
    wb_rsp_t rest_rsp;
    wb_req_t ram_req;
    wb_rsp_t ram_rsp;

    logic   charge;
    money_t charge_amount;

    logic  coin_tone_start;
    note_t coin_tone_note;
    logic  sale_tone_start;
    note_t sale_tone_note;
    logic  tone_start;
    note_t tone_note;

    // coin and selection tones never start in the same cycle
    assign tone_start = coin_tone_start | sale_tone_start;
    assign tone_note  = coin_tone_start ? coin_tone_note : sale_tone_note;

    sale_controller u_sale (
        .clk(clk), .rst(rst), .keys(keys), .credit(credit),
        .cursor(cursor), .selected(selected), .vend(vend), .vend_item(vend_item),
        .charge(charge), .charge_amount(charge_amount),
        .tone_start(sale_tone_start), .tone_note(sale_tone_note),
        .wb_req(sale_req), .wb_rsp(sale_rsp)
    );

    restock_controller u_restock (
        .clk(clk), .rst(rst), .add(keys.add), .admin_mode(admin_mode),
        .cursor(cursor), .wb_req(rest_req), .wb_rsp(rest_rsp)
    );

    stock_arbiter u_arb (
        .clk(clk), .rst(rst),
        .m0_req(sale_req), .m0_rsp(sale_rsp),
        .m1_req(rest_req), .m1_rsp(rest_rsp),
        .s_req(ram_req), .s_rsp(ram_rsp)
    );

    stock_ram u_ram (
        .clk(clk), .rst(rst), .wb_req(ram_req), .wb_rsp(ram_rsp),
        .disp_adr(cursor), .disp_count(shown_count)
    );

    coin_bank #(.RETURN_TICKS(RETURN_TICKS)) u_bank (
        .clk(clk), .rst(rst), .coin(keys.coin), .ret(keys.ret),
        .charge(charge), .charge_amount(charge_amount),
        .credit(credit), .returning(returning),
        .tone_start(coin_tone_start), .tone_note(coin_tone_note)
    );

    tone_sequencer #(.PHASE_TICKS(PHASE_TICKS)) u_tone (
        .clk(clk), .rst(rst), .start(tone_start), .note(tone_note),
        .note_state(note_state), .note_played(note_played)
    );

endmodule

/* tests/tb_vending_machine.sv */
`timescale 1ns/100ps

module tb_vending_machine;
    import vend_pkg::*;
    import bus_pkg::*;

    // columns per golden line and room for the steps
    localparam int COLS      = 10;
    localparam int MAX_STEPS = 64;

    logic     clk;
    logic     rst;
    keys_t    keys;
    logic     admin_mode;
    money_t   credit;
    count_t   shown_count;
    prod_id_t cursor;
    prod_id_t selected;
    logic     vend;
    prod_id_t vend_item;
    logic     returning;
    note_t    note_state;
    phase_t   note_played;

    logic [11:0] golden [0:COLS*MAX_STEPS-1];
    int          num_steps;
    int          timeout_cycles;
    logic        loaded;
    int          checks;
    int          errors;
    int          test_errors;
    int          test_count;
    prod_id_t    exp_cursor;

    vending_machine #(.RETURN_TICKS(4), .PHASE_TICKS(3)) UUT (
        .clk(clk), .rst(rst), .keys(keys), .admin_mode(admin_mode),
        .credit(credit), .shown_count(shown_count), .cursor(cursor),
        .selected(selected), .vend(vend), .vend_item(vend_item),
        .returning(returning), .note_state(note_state), .note_played(note_played)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_mismatch(input int step, input string name,
                                   input logic [11:0] got, input logic [11:0] exp);
        $display("MISMATCH step %0d %s: got %h expected %h", step, name, got, exp);
        errors++;
        test_errors++;
    endtask

    //////////////////////////////
    // one golden line
    //////////////////////////////

    task automatic run_step(input int idx);
        int       base;
        int       wait_cycles;
        int       vend_cnt;
        logic     tone_seen;
        keys_t    key;
        prod_id_t exp_item;
        phase_t   max_phase;
        phase_t   exp_phase;
        base        = idx * COLS;
        wait_cycles = golden[base + 3];
        vend_cnt    = 0;
        tone_seen   = 1'b0;
        key         = keys_t'(golden[base + 1][8:0]);
        // the item bought is the one selected after the previous step
        exp_item    = (idx == 0) ? prod_id_t'(0) : prod_id_t'(golden[base - COLS + 6]);
        max_phase   = '0;
        exp_phase   = golden[base + 9][0] ? 3'd4 : 3'd0;
        // cursor saturates at both ends
        if (key.up && exp_cursor > 2'd1)
            exp_cursor = exp_cursor - 2'd1;
        else if (key.down && exp_cursor < 2'd3)
            exp_cursor = exp_cursor + 2'd1;
        @(posedge clk);
        #2;
        keys       = key;
        admin_mode = golden[base + 2][0];
        @(posedge clk);
        #2;
        keys = '0;
        // outputs settle between edges, so sample on the falling edge
        repeat (wait_cycles) begin
            @(negedge clk);
            if (vend) begin
                vend_cnt++;
                if (vend_item !== exp_item)
                    report_mismatch(idx + 1, "vend_item", vend_item, exp_item);
            end
            if (note_state != NOTE_NONE)
                tone_seen = 1'b1;
            if (note_played > max_phase)
                max_phase = note_played;
        end
        checks += 10;
        if (credit !== golden[base + 4])
            report_mismatch(idx + 1, "credit", credit, golden[base + 4]);
        if (shown_count !== golden[base + 5])
            report_mismatch(idx + 1, "shown_count", shown_count, golden[base + 5]);
        if (selected !== golden[base + 6])
            report_mismatch(idx + 1, "selected", selected, golden[base + 6]);
        if (vend_cnt != golden[base + 7])
            report_mismatch(idx + 1, "vend count", 12'(vend_cnt), golden[base + 7]);
        if (returning !== golden[base + 8][0])
            report_mismatch(idx + 1, "returning", returning, golden[base + 8]);
        if (tone_seen !== golden[base + 9][0])
            report_mismatch(idx + 1, "tone heard", tone_seen, golden[base + 9]);
        if (cursor !== exp_cursor)
            report_mismatch(idx + 1, "cursor", cursor, exp_cursor);
        // a tone plays all four phases
        if (max_phase !== exp_phase)
            report_mismatch(idx + 1, "note_played peak", max_phase, exp_phase);
        // every window is long enough for the tone to finish
        if (note_state !== NOTE_NONE)
            report_mismatch(idx + 1, "note_state", 12'(note_state), 12'(NOTE_NONE));
        if (note_played !== 3'd0)
            report_mismatch(idx + 1, "note_played", note_played, 12'h0);
    endtask

    initial begin
        rst         = 1'b0;
        keys        = '0;
        admin_mode  = 1'b0;
        loaded      = 1'b0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        test_count  = 0;
        exp_cursor  = 2'd1;
        for (int i = 0; i < COLS * MAX_STEPS; i++) begin
            golden[i] = 12'hfff;
        end
        $readmemh("tests/vending_golden.txt", golden);
        // two cycles per step for the key itself, plus reset and margin
        num_steps      = 0;
        timeout_cycles = 53;
        while (num_steps < MAX_STEPS && golden[num_steps * COLS] != 12'hfff) begin
            timeout_cycles += golden[num_steps * COLS + 3] + 2;
            num_steps++;
        end
        loaded = 1'b1;
        if (num_steps == 0) begin
            $display("the golden file held no steps");
            errors++;
        end
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b1;
        for (int i = 0; i < num_steps; i++) begin
            run_step(i);
            if (i == num_steps - 1 || golden[(i + 1) * COLS] != golden[i * COLS]) begin
                $display("test %0d finished with %0d errors", golden[i * COLS], test_errors);
                test_count++;
                test_errors = 0;
            end
        end
        $display("%0d tests, %0d steps, %0d checks, %0d errors",
                 test_count, num_steps, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (loaded);
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", timeout_cycles);
        $display("test failed");
        $finish;
    end

endmodule

/* tests/vending_golden.txt */
// test key admin wait credit shown_count selected vend_count returning tone, all hex
// key bits: up 100, down 080, sel 040, buy 020, ret 010, add 008, coins 001 002 004
1 000 0 10 00 5 0 0 0 0
1 001 0 10 01 5 0 0 0 1
1 002 0 10 06 5 0 0 0 1
1 004 0 10 10 5 0 0 0 1
1 000 0 10 10 5 0 0 0 0
2 100 0 10 10 5 0 0 0 0
2 080 0 10 10 1 0 0 0 0
2 080 0 10 10 0 0 0 0 0
2 080 0 10 10 0 0 0 0 0
2 040 0 14 10 0 0 0 0 0
2 100 0 10 10 1 0 0 0 0
2 100 0 10 10 5 0 0 0 0
2 040 0 14 10 5 1 0 0 1
2 040 0 10 10 5 0 0 0 0
3 080 0 10 10 1 0 0 0 0
3 040 0 14 10 1 2 0 0 1
3 020 0 14 04 0 0 1 0 0
3 100 0 10 04 5 0 0 0 0
3 040 0 14 04 5 1 0 0 1
3 020 0 14 04 5 1 0 0 0
4 008 1 10 04 6 1 0 0 0
4 008 1 10 04 7 1 0 0 0
4 008 1 10 04 8 1 0 0 0
4 008 1 10 04 9 1 0 0 0
4 008 1 10 04 9 1 0 0 0
4 080 0 10 04 0 1 0 0 0
4 008 0 10 04 0 1 0 0 0
4 008 1 10 04 1 1 0 0 0
5 004 0 10 0e 1 1 0 0 1
5 010 0 0a 0c 1 1 0 1 0
5 000 0 3c 00 1 1 0 0 0
6 001 0 10 01 1 1 0 0 1
6 002 0 10 06 1 1 0 0 1

/* vending_machine.f */
verilog/vend_pkg.sv
verilog/bus_pkg.sv
verilog/stock_ram.sv
verilog/stock_arbiter.sv
verilog/sale_controller.sv
verilog/restock_controller.sv
verilog/coin_bank.sv
verilog/tone_sequencer.sv
verilog/vending_machine.sv
tests/tb_vending_machine.sv
